//--- exec_stage.f
hw/exec_pkg.sv
hw/exec_intf.sv
hw/alu_unit.sv
hw/step_counter.sv
hw/mul_iter.sv
hw/exec_ctrl.sv
hw/exec_stage.sv
sim/exec_stage_chk.sv
sim/exec_stage_mon.sv
sim/exec_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module exec_stage_tb -f exec_stage.f -o exec_stage_sim \
  && ./obj_dir/exec_stage_sim +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "RESULT: PASS" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- sim/exec_stage_tb.sv
// Execute stage testbench
// Random instruction stream and random writeback back-pressure from a seeded LCG

`timescale 1ns/1ps
`default_nettype none

module exec_stage_tb import exec_pkg::*; ();

  localparam int SEQ_BITS    = 6;
  localparam int NUM_INSTR   = 400;
  localparam int SEND_LIMIT  = 20000;
  localparam int DRAIN_LIMIT = 2000;

  logic                clk;
  logic                rst_n;
  logic                d_val;
  logic                d_rdy;
  logic [31:0]         d_pc;
  logic [SEQ_BITS-1:0] d_seq_num;
  logic [XLEN-1:0]     d_op1;
  logic [XLEN-1:0]     d_op2;
  logic [4:0]          d_waddr;
  rv_uop               d_uop;
  logic                w_val;
  logic                w_rdy;
  logic [31:0]         w_pc;
  logic [SEQ_BITS-1:0] w_seq_num;
  logic [4:0]          w_waddr;
  logic [XLEN-1:0]     w_wdata;
  logic                w_wen;

  int                  mon_errors;
  int                  mon_pending;
  int                  sent;
  int                  cycles;
  int                  timeouts;
  logic [SEQ_BITS-1:0] next_seq;
  logic [31:0]         lcg_state;
  logic [31:0]         pc_word;

  exec_stage #(.SEQ_BITS(SEQ_BITS)) DUT (.*);

  exec_stage_mon #(.SEQ_BITS(SEQ_BITS)) u_mon (
    .clk (clk), .rst_n (rst_n),
    .d_val (d_val), .d_rdy (d_rdy), .d_pc (d_pc), .d_seq_num (d_seq_num),
    .d_op1 (d_op1), .d_op2 (d_op2), .d_waddr (d_waddr), .d_uop (d_uop),
    .w_val (w_val), .w_rdy (w_rdy), .w_pc (w_pc), .w_seq_num (w_seq_num),
    .w_waddr (w_waddr), .w_wdata (w_wdata), .w_wen (w_wen),
    .errors (mon_errors), .pending (mon_pending)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // --------------------
  // Random numbers
  // --------------------

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Upper LCG bits are the better ones
  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = next_rand();
    return {16'd0, r[31:16]} % n;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[31:16], lo[31:16]};
  endfunction

  // Corner values mixed in with plain random words
  function automatic logic [31:0] rand_operand();
    case (rand_below(8))
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      2:       return 32'h8000_0000;
      3:       return 32'h7fff_ffff;
      4:       return 32'(rand_below(40));
      default: return rand_word();
    endcase
  endfunction

  // About one MUL in eight
  function automatic rv_uop rand_uop();
    if (rand_below(8) == 0) begin
      return UOP_MUL;
    end
    return rv_uop'(4'(rand_below(9)));
  endfunction

  // --------------------
  // Per-cycle driver
  // --------------------

  task automatic drive_cycle(input bit allow_send);
    bit fired;
    @(posedge clk);
    fired = d_val && d_rdy;
    if (fired) begin
      sent++;
      next_seq++;
    end
    #1;
    w_rdy = (rand_below(3) != 0);
    // Hold a stalled message, else offer a new one
    if (!d_val || fired) begin
      if (allow_send && (sent < NUM_INSTR) && (rand_below(4) != 0)) begin
        pc_word   = rand_word();
        d_val     = 1'b1;
        d_pc      = {pc_word[31:2], 2'b00};
        d_seq_num = next_seq;
        d_op1     = rand_operand();
        d_op2     = rand_operand();
        d_uop     = rand_uop();
        d_waddr   = (rand_below(4) == 0) ? 5'd0 : 5'(rand_below(32));
      end else begin
        d_val = 1'b0;
      end
    end
    cycles++;
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    d_val     = 1'b0;
    d_pc      = '0;
    d_seq_num = '0;
    d_op1     = '0;
    d_op2     = '0;
    d_waddr   = '0;
    d_uop     = UOP_ADD;
    w_rdy     = 1'b0;
    lcg_state = 32'd86644;
    next_seq  = '0;
    sent      = 0;
    cycles    = 0;
    timeouts  = 0;

    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    while ((sent < NUM_INSTR) && (cycles < SEND_LIMIT)) begin
      drive_cycle(1'b1);
    end
    if (sent < NUM_INSTR) begin
      timeouts++;
      $display("Timed out with only %0d of %0d instructions accepted", sent, NUM_INSTR);
    end

    // Let the last results drain under back-pressure
    cycles = 0;
    while ((mon_pending != 0) && (cycles < DRAIN_LIMIT)) begin
      drive_cycle(1'b0);
    end
    if (mon_pending != 0) begin
      timeouts++;
      $display("Timed out waiting for %0d results to leave the stage", mon_pending);
    end

    $display("Errors: %0d compare, %0d assertion, %0d timeout",
             mon_errors, DUT.u_chk.fail_count, timeouts);
    if ((mon_errors + DUT.u_chk.fail_count + timeouts) == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/exec_stage_mon.sv
// Execute stage monitor
// Keeps a queue of expected writeback messages from a reference model
// and compares every writeback transfer against its head

`timescale 1ns/1ps
`default_nettype none

module exec_stage_mon import exec_pkg::*; #(
  parameter int SEQ_BITS = 5
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                d_val,
  input  logic                d_rdy,
  input  logic [31:0]         d_pc,
  input  logic [SEQ_BITS-1:0] d_seq_num,
  input  logic [XLEN-1:0]     d_op1,
  input  logic [XLEN-1:0]     d_op2,
  input  logic [4:0]          d_waddr,
  input  rv_uop               d_uop,
  input  logic                w_val,
  input  logic                w_rdy,
  input  logic [31:0]         w_pc,
  input  logic [SEQ_BITS-1:0] w_seq_num,
  input  logic [4:0]          w_waddr,
  input  logic [XLEN-1:0]     w_wdata,
  input  logic                w_wen,
  output int                  errors,
  output int                  pending
);

  typedef struct packed {
    logic [31:0]         pc;
    logic [SEQ_BITS-1:0] seq_num;
    logic [4:0]          waddr;
    logic [XLEN-1:0]     wdata;
    logic                wen;
  } wb_msg_t;

  wb_msg_t             exp_q[$];
  wb_msg_t             exp_msg;
  logic                alu_fire_q;
  logic [SEQ_BITS-1:0] alu_seq_q;

  // --------------------
  // Reference model
  // --------------------

  function automatic logic [XLEN-1:0] model_result(input rv_uop uop,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
    case (uop)
      UOP_ADD:  return a + b;
      UOP_SUB:  return a - b;
      UOP_AND:  return a & b;
      UOP_OR:   return a | b;
      UOP_XOR:  return a ^ b;
      UOP_SLT:  return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
      UOP_SLTU: return (a < b) ? XLEN'(1) : XLEN'(0);
      // Shift amount is the low 5 bits only
      UOP_SLL:  return a << b[4:0];
      UOP_SRL:  return a >> b[4:0];
      // Low half of the full product
      UOP_MUL:  return a * b;
      default:  return '0;
    endcase
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: seq %0d %s got %h expected %h",
               $time, exp_msg.seq_num, name, got, exp);
    end
  endtask

  // --------------------
  // Transfer tracking
  // --------------------

  always @(posedge clk) begin
    if (!rst_n) begin
      errors     = 0;
      alu_fire_q = 1'b0;
      exp_q.delete();
    end else begin
      // Single-cycle op must sit on writeback one edge after issue
      if (alu_fire_q && !(w_val && (w_seq_num == alu_seq_q))) begin
        errors++;
        $display("Single-cycle op seq %0d was not on writeback one cycle after issue at %0t ns",
                 alu_seq_q, $time);
      end
      // Pop first, the output register never holds this edge's issue
      if (w_val && w_rdy) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Writeback message seq %0d arrived with no instruction outstanding",
                   w_seq_num);
        end else begin
          exp_msg = exp_q.pop_front();
          check_field("pc", w_pc, exp_msg.pc);
          check_field("seq_num", 32'(w_seq_num), 32'(exp_msg.seq_num));
          check_field("waddr", 32'(w_waddr), 32'(exp_msg.waddr));
          check_field("wdata", w_wdata, exp_msg.wdata);
          check_field("wen", 32'(w_wen), 32'(exp_msg.wen));
        end
      end
      if (d_val && d_rdy) begin
        exp_q.push_back({d_pc, d_seq_num, d_waddr,
                         model_result(d_uop, d_op1, d_op2), (d_waddr != 5'd0)});
      end
      alu_fire_q = d_val && d_rdy && (d_uop != UOP_MUL);
      alu_seq_q  = d_seq_num;
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

//--- sim/exec_stage_chk.sv
// Execute stage handshake checker
// Concurrent assertions on the decode and writeback handshakes, bound into the top level

`timescale 1ns/1ps
`default_nettype none

module exec_stage_chk import exec_pkg::*; #(
  parameter int SEQ_BITS = 5
) (
  input logic                clk,
  input logic                rst_n,
  input logic                d_rdy,
  input logic                w_val,
  input logic                w_rdy,
  input logic [31:0]         w_pc,
  input logic [SEQ_BITS-1:0] w_seq_num,
  input logic [4:0]          w_waddr,
  input logic [XLEN-1:0]     w_wdata,
  input logic                w_wen,
  input exec_state           state
);

  // Read by the testbench at the end of the run
  int fail_count = 0;

  // --------------------
  // Writeback side
  // --------------------

  // Stalled message stays put, fields included
  property w_hold_p;
    @(posedge clk) disable iff (!rst_n)
      (w_val && !w_rdy) |=> (w_val && $stable({w_pc, w_seq_num, w_waddr, w_wdata, w_wen}));
  endproperty

  w_hold_a: assert property (w_hold_p) else begin
    fail_count++;
    $error("Writeback message changed or dropped while stalled");
  end

  // Output register empty while in reset
  property w_reset_p;
    @(posedge clk) !rst_n |-> !w_val;
  endproperty

  w_reset_a: assert property (w_reset_p) else begin
    fail_count++;
    $error("w_val high during reset");
  end

  // --------------------
  // Decode side
  // --------------------

  // No issue while a MUL runs or a product is parked
  property d_busy_p;
    @(posedge clk) disable iff (!rst_n)
      (state != ST_IDLE) |-> !d_rdy;
  endproperty

  d_busy_a: assert property (d_busy_p) else begin
    fail_count++;
    $error("d_rdy high outside the idle state");
  end

endmodule

bind exec_stage exec_stage_chk #(.SEQ_BITS(SEQ_BITS)) u_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .d_rdy     (d_rdy),
  .w_val     (w_val),
  .w_rdy     (w_rdy),
  .w_pc      (w_pc),
  .w_seq_num (w_seq_num),
  .w_waddr   (w_waddr),
  .w_wdata   (w_wdata),
  .w_wen     (w_wen),
  .state     (u_ctrl.state)
);

`default_nettype wire

//--- hw/exec_stage.sv
// Execute stage top level
// Plain decode and writeback ports, control, ALU and iterative multiplier

`timescale 1ns/1ps
`default_nettype none

module exec_stage import exec_pkg::*; #(
  parameter int SEQ_BITS = 5
) (
  input  logic                clk,
  input  logic                rst_n,
  // Decode side
  input  logic                d_val,
  output logic                d_rdy,
  input  logic [31:0]         d_pc,
  input  logic [SEQ_BITS-1:0] d_seq_num,
  input  logic [XLEN-1:0]     d_op1,
  input  logic [XLEN-1:0]     d_op2,
  input  logic [4:0]          d_waddr,
  input  rv_uop               d_uop,
  // Writeback side
  output logic                w_val,
  input  logic                w_rdy,
  output logic [31:0]         w_pc,
  output logic [SEQ_BITS-1:0] w_seq_num,
  output logic [4:0]          w_waddr,
  output logic [XLEN-1:0]     w_wdata,
  output logic                w_wen
);

  d_x_if #(.SEQ_BITS(SEQ_BITS)) d_x ();
  x_w_if #(.SEQ_BITS(SEQ_BITS)) x_w ();
  mul_if                        mul_bus ();

  rv_uop           alu_uop;
  logic [XLEN-1:0] alu_op1;
  logic [XLEN-1:0] alu_op2;
  logic [XLEN-1:0] alu_result;

  // --------------------
  // Port to interface
  // --------------------

  assign d_x.val     = d_val;
  assign d_x.pc      = d_pc;
  assign d_x.seq_num = d_seq_num;
  assign d_x.op1     = d_op1;
  assign d_x.op2     = d_op2;
  assign d_x.waddr   = d_waddr;
  assign d_x.uop     = d_uop;
  assign d_rdy       = d_x.rdy;

  assign w_val       = x_w.val;
  assign w_pc        = x_w.pc;
  assign w_seq_num   = x_w.seq_num;
  assign w_waddr     = x_w.waddr;
  assign w_wdata     = x_w.wdata;
  assign w_wen       = x_w.wen;
  assign x_w.rdy     = w_rdy;

  // --------------------
  // Units
  // --------------------

  exec_ctrl #(.SEQ_BITS(SEQ_BITS)) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .d          (d_x.sink),
    .w          (x_w.source),
    .mul        (mul_bus.ctrl),
    .alu_uop    (alu_uop),
    .alu_op1    (alu_op1),
    .alu_op2    (alu_op2),
    .alu_result (alu_result)
  );

  alu_unit u_alu (
    .uop    (alu_uop),
    .op1    (alu_op1),
    .op2    (alu_op2),
    .result (alu_result)
  );

  mul_iter u_mul (
    .clk   (clk),
    .rst_n (rst_n),
    .mul   (mul_bus.unit)
  );

endmodule

`default_nettype wire

//--- hw/exec_ctrl.sv
// Execute stage control
// Issue FSM, operand steering to the ALU and multiplier, and the
// output register toward writeback

`timescale 1ns/1ps
`default_nettype none

module exec_ctrl import exec_pkg::*; #(
  parameter int SEQ_BITS = 5
) (
  input  logic            clk,
  input  logic            rst_n,
  d_x_if.sink             d,
  x_w_if.source           w,
  mul_if.ctrl             mul,
  output rv_uop           alu_uop,
  output logic [XLEN-1:0] alu_op1,
  output logic [XLEN-1:0] alu_op2,
  input  logic [XLEN-1:0] alu_result
);

  exec_state state;
  exec_state state_nxt;

  logic                d_fire;
  logic                is_mul;
  logic                out_free;
  logic                load_alu;
  logic                load_mul;
  logic                out_load;
  logic [31:0]         pc_q;
  logic [SEQ_BITS-1:0] seq_q;
  logic [4:0]          waddr_q;
  logic [XLEN-1:0]     prod_q;
  logic                w_val_q;
  logic [31:0]         w_pc_q;
  logic [SEQ_BITS-1:0] w_seq_q;
  logic [4:0]          w_waddr_q;
  logic [XLEN-1:0]     w_wdata_q;

  // --------------------
  // Issue side
  // --------------------

  // Output slot free, or drained this cycle
  assign out_free = !w_val_q || w.rdy;
  assign d.rdy    = (state == ST_IDLE) && !mul.busy && out_free;
  assign d_fire   = d.val && d.rdy;
  assign is_mul   = (d.uop == UOP_MUL);

  // ALU sees the incoming message directly
  assign alu_uop = d.uop;
  assign alu_op1 = d.op1;
  assign alu_op2 = d.op2;

  // Multiplier loads on the issue edge
  assign mul.start = d_fire && is_mul;
  assign mul.op1   = d.op1;
  assign mul.op2   = d.op2;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: if (d_fire && is_mul) state_nxt = ST_MUL;
      // Park the product when the output slot is busy
      ST_MUL:  if (mul.done) state_nxt = out_free ? ST_IDLE : ST_FULL;
      ST_FULL: if (out_free) state_nxt = ST_IDLE;
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Tags and product for the MUL in flight
  always_ff @(posedge clk) begin
    if (d_fire) begin
      pc_q    <= d.pc;
      seq_q   <= d.seq_num;
      waddr_q <= d.waddr;
    end
    if (mul.done) begin
      prod_q <= mul.product;
    end
  end

  // --------------------
  // Output register
  // --------------------

  assign load_alu = d_fire && !is_mul;
  assign load_mul = ((state == ST_MUL) && mul.done) || (state == ST_FULL);
  assign out_load = load_alu || (load_mul && out_free);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_val_q <= 1'b0;
    end else if (out_load) begin
      w_val_q <= 1'b1;
    end else if (w.rdy) begin
      w_val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_alu) begin
      w_pc_q    <= d.pc;
      w_seq_q   <= d.seq_num;
      w_waddr_q <= d.waddr;
      w_wdata_q <= alu_result;
    end else if (out_load) begin
      w_pc_q    <= pc_q;
      w_seq_q   <= seq_q;
      w_waddr_q <= waddr_q;
      // Fresh product in ST_MUL, parked one in ST_FULL
      w_wdata_q <= (state == ST_MUL) ? mul.product : prod_q;
    end
  end

  assign w.val     = w_val_q;
  assign w.pc      = w_pc_q;
  assign w.seq_num = w_seq_q;
  assign w.waddr   = w_waddr_q;
  assign w.wdata   = w_wdata_q;
  // x0 never written
  assign w.wen     = (w_waddr_q != 5'd0);

endmodule

`default_nettype wire

//--- hw/mul_iter.sv
// Iterative shift-add multiplier
// One partial product per cycle, returns the low XLEN bits of op1 * op2

`timescale 1ns/1ps
`default_nettype none

module mul_iter import exec_pkg::*; (
  input logic clk,
  input logic rst_n,
  mul_if.unit mul
);

  logic            cnt_busy;
  logic            cnt_last;
  logic [XLEN-1:0] mcand;
  logic [XLEN-1:0] mplier;
  logic [XLEN-1:0] acc;
  logic            done_q;

  // Counter paces the steps, it runs while nonzero
  step_counter u_cnt (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (mul.start),
    .step  (cnt_busy),
    .last  (cnt_last),
    .busy  (cnt_busy)
  );

  // --------------------
  // Datapath
  // --------------------

  always_ff @(posedge clk) begin
    if (mul.start) begin
      mcand  <= mul.op1;
      mplier <= mul.op2;
      acc    <= '0;
    end else if (cnt_busy) begin
      // Add shifted multiplicand on a set bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // done lands the cycle after the final step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else begin
      done_q <= cnt_last;
    end
  end

  assign mul.busy    = cnt_busy;
  assign mul.done    = done_q;
  assign mul.product = acc;

endmodule

`default_nettype wire

//--- hw/step_counter.sv
// Multiplier step counter
// Loads MUL_STEPS, counts down once per step and flags the final step

`timescale 1ns/1ps
`default_nettype none

module step_counter import exec_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic load,
  input  logic step,
  output logic last,
  output logic busy
);

  localparam int CNT_W = $clog2(MUL_STEPS + 1);

  logic [CNT_W-1:0] count;

  // Load wins over step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= CNT_W'(MUL_STEPS);
    end else if (step && busy) begin
      count <= count - CNT_W'(1);
    end
  end

  assign busy = (count != '0);
  // High during the cycle of the final step
  assign last = step && (count == CNT_W'(1));

endmodule

`default_nettype wire

//--- hw/alu_unit.sv
// Single-cycle integer ALU
// Purely combinational, covers every micro-op except MUL

`timescale 1ns/1ps
`default_nettype none

module alu_unit import exec_pkg::*; (
  input  rv_uop           uop,
  input  logic [XLEN-1:0] op1,
  input  logic [XLEN-1:0] op2,
  output logic [XLEN-1:0] result
);

  // Shift amount width, 5 bits for RV32
  localparam int SHAMT_BITS = $clog2(XLEN);

  logic [SHAMT_BITS-1:0] shamt;
  logic                  lt_signed;
  logic                  lt_unsigned;

  // Only the low bits of op2 count for shifts
  assign shamt = op2[SHAMT_BITS-1:0];

  // Compares
  assign lt_signed   = $signed(op1) < $signed(op2);
  assign lt_unsigned = op1 < op2;

  // --------------------
  // Operation table
  // --------------------

  always_comb begin
    case (uop)
      // Add and sub wrap at XLEN bits
      UOP_ADD:  result = op1 + op2;
      UOP_SUB:  result = op1 - op2;

      // Bitwise logic
      UOP_AND:  result = op1 & op2;
      UOP_OR:   result = op1 | op2;
      UOP_XOR:  result = op1 ^ op2;

      // Set-less-than gives 0 or 1
      UOP_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
      UOP_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};

      // Logical shifts, zero fill
      UOP_SLL:  result = op1 << shamt;
      UOP_SRL:  result = op1 >> shamt;

      // MUL goes to the multiplier, result unused here
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/exec_intf.sv
// Execute stage interfaces
// Decode to execute, execute to writeback, and the multiplier control bus

`timescale 1ns/1ps
`default_nettype none

// --------------------
// Decode to execute
// --------------------

interface d_x_if import exec_pkg::*; #(
  parameter int SEQ_BITS = 5
) ();
  logic                val;
  logic                rdy;
  logic [31:0]         pc;
  logic [SEQ_BITS-1:0] seq_num;
  logic [XLEN-1:0]     op1;
  logic [XLEN-1:0]     op2;
  logic [4:0]          waddr;
  rv_uop               uop;

  // Execute side receives the message
  modport sink (input val, pc, seq_num, op1, op2, waddr, uop, output rdy);
endinterface

// --------------------
// Execute to writeback
// --------------------

interface x_w_if import exec_pkg::*; #(
  parameter int SEQ_BITS = 5
) ();
  logic                val;
  logic                rdy;
  logic [31:0]         pc;
  logic [SEQ_BITS-1:0] seq_num;
  logic [4:0]          waddr;
  logic [XLEN-1:0]     wdata;
  logic                wen;

  modport source (output val, pc, seq_num, waddr, wdata, wen, input rdy);
endinterface

// --------------------
// Multiplier bus
// --------------------

interface mul_if import exec_pkg::*; ();
  // start and done are single-cycle pulses
  logic            start;
  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic            busy;
  logic            done;
  logic [XLEN-1:0] product;

  modport ctrl (output start, op1, op2, input busy, done, product);
  modport unit (input start, op1, op2, output busy, done, product);
endinterface

`default_nettype wire

//--- hw/exec_pkg.sv
// Shared definitions for the execute stage
// Data width, multiplier step count, micro-op and FSM state encodings

`default_nettype none

package exec_pkg;

  // --------------------
  // Datapath sizing
  // --------------------

  // Operand and result width
  localparam int XLEN = 32;

  // One partial-product step per multiplier bit
  localparam int MUL_STEPS = XLEN;

  // --------------------
  // Micro-ops
  // --------------------

  typedef enum logic [3:0] {
    UOP_ADD  = 4'd0,
    UOP_SUB  = 4'd1,
    UOP_AND  = 4'd2,
    UOP_OR   = 4'd3,
    UOP_XOR  = 4'd4,
    UOP_SLT  = 4'd5,
    UOP_SLTU = 4'd6,
    UOP_SLL  = 4'd7,
    UOP_SRL  = 4'd8,
    // Only multi-cycle op
    UOP_MUL  = 4'd9
  } rv_uop;

  // --------------------
  // Issue FSM states
  // --------------------

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_MUL  = 2'd1,
    ST_FULL = 2'd2
  } exec_state;

endpackage

`default_nettype wire
